// ==== Bender.yml ====
package:
  name: periph_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/bus_pkg.sv
      - hw/periph_pkg.sv
      - hw/mem_block.sv
      - hw/gpio_port.sv
      - hw/resp_merge.sv
      - hw/periph_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_periph_subsystem.sv

// ==== hw/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  typedef logic [31:0] addr_t;  // Byte address
  typedef logic [31:0] data_t;  // Data word
  typedef logic [15:0] inst_t;  // Instruction halfword

  // Fetch response carries the request address back with the instruction
  typedef struct packed {
    inst_t inst;
    addr_t addr;
  } fetch_rsp_t;

endpackage

`default_nettype wire

// ==== hw/gpio_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_port
  import bus_pkg::*;
  import periph_pkg::*;
#(
  parameter addr_t BASE_ADDR = 32'h8000_0000
) (
  input  wire             core_clk,
  input  wire             rst_i,

  input  wire             mem_valid_i,
  input  wire             mem_read_i,
  input  wire             mem_write_i,
  input  wire addr_t      mem_addr_i,
  input  wire data_t      mem_wdata_i,
  output logic            mem_valid_o,
  output data_t           mem_rdata_o,

  input  wire gpio_pins_t pin_in_i,
  output gpio_pins_t      pin_out_o,
  output gpio_pins_t      pin_oe_o
);

  logic       hit;
  logic [3:0] reg_off;
  gpio_pins_t out_q;
  gpio_pins_t dir_q;
  gpio_pins_t in_q;
  data_t      rd_data;

  assign hit     = mem_valid_i && (mem_addr_i[31:4] == BASE_ADDR[31:4]);  // 16-byte window
  assign reg_off = {mem_addr_i[3:2], 2'b00};

  always_comb begin
    rd_data = '0;  // Offset 0xC reads zero
    case (reg_off)
      GPIO_REG_OUT: rd_data = data_t'(out_q);
      GPIO_REG_DIR: rd_data = data_t'(dir_q);
      GPIO_REG_IN:  rd_data = data_t'(in_q);
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge core_clk) begin
    if (rst_i) begin
      out_q       <= '0;
      dir_q       <= '0;
      mem_valid_o <= 1'b0;
    end else begin
      mem_valid_o <= hit;
      if (hit && mem_write_i) begin
        case (reg_off)
          GPIO_REG_OUT: out_q <= gpio_pins_t'(mem_wdata_i);
          GPIO_REG_DIR: dir_q <= gpio_pins_t'(mem_wdata_i);
          default: ;    // Input register is read only
        endcase
      end
    end
  end

  // Single sampling stage on the pins
  always_ff @(posedge core_clk) begin
    in_q <= pin_in_i;
    if (hit) begin
      mem_rdata_o <= (mem_read_i && !mem_write_i) ? rd_data : '0;
    end
  end

  assign pin_out_o = out_q;
  assign pin_oe_o  = dir_q;

endmodule

`default_nettype wire

// ==== hw/mem_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_block
  import bus_pkg::*;
#(
  parameter addr_t BASE_ADDR = 32'h2000_0000,
  parameter int    MEM_DEPTH = 256
) (
  input  wire        core_clk,
  input  wire        rst_i,

  input  wire        fetch_valid_i,
  input  wire addr_t fetch_addr_i,
  output logic       fetch_valid_o,
  output fetch_rsp_t fetch_rsp_o,

  input  wire        mem_valid_i,
  input  wire        mem_read_i,
  input  wire        mem_write_i,
  input  wire addr_t mem_addr_i,
  input  wire data_t mem_wdata_i,
  output logic       mem_valid_o,
  output data_t      mem_rdata_o
);

  localparam int    IDX_W     = $clog2(MEM_DEPTH);
  localparam addr_t MEM_BYTES = addr_t'(MEM_DEPTH * 4);

  data_t mem_q [MEM_DEPTH];

  addr_t            fetch_off;
  addr_t            data_off;
  logic             fetch_hit;
  logic             data_hit;
  logic [IDX_W-1:0] fetch_idx;
  logic [IDX_W-1:0] data_idx;
  data_t            fetch_word;
  fetch_rsp_t       fetch_rsp_d;

  // Offsets wrap below the base, so one compare covers the range
  assign fetch_off = fetch_addr_i - BASE_ADDR;
  assign data_off  = mem_addr_i - BASE_ADDR;
  assign fetch_hit = fetch_valid_i && (fetch_off < MEM_BYTES);
  assign data_hit  = mem_valid_i && (data_off < MEM_BYTES);
  assign fetch_idx = fetch_off[IDX_W+1:2];
  assign data_idx  = data_off[IDX_W+1:2];

  assign fetch_word = mem_q[fetch_idx];

  // Bit 1 low picks the upper halfword
  assign fetch_rsp_d = '{
    inst: (fetch_addr_i[1] ? fetch_word[15:0] : fetch_word[31:16]),
    addr: fetch_addr_i
  };

  // Array and read data, same-edge reads see the old word
  always_ff @(posedge core_clk) begin
    if (data_hit && mem_write_i) begin
      mem_q[data_idx] <= mem_wdata_i;
    end
    if (data_hit) begin
      mem_rdata_o <= (mem_read_i && !mem_write_i) ? mem_q[data_idx] : '0;  // Writes answer zero
    end
    if (fetch_hit) begin
      fetch_rsp_o <= fetch_rsp_d;
    end
  end

  always_ff @(posedge core_clk) begin
    if (rst_i) begin
      fetch_valid_o <= 1'b0;
      mem_valid_o   <= 1'b0;
    end else begin
      fetch_valid_o <= fetch_hit;
      mem_valid_o   <= data_hit;
    end
  end

endmodule

`default_nettype wire

// ==== hw/periph_pkg.sv ====
`default_nettype none

`include "periph_consts.svh"

package periph_pkg;

  // Word offsets inside a GPIO window
  typedef enum logic [3:0] {
    GPIO_REG_OUT = 4'h0,  // Output data
    GPIO_REG_DIR = 4'h4,  // Direction, 1 drives the pin
    GPIO_REG_IN  = 4'h8   // Sampled input, read only
  } gpio_reg_e;

  typedef logic [`PS_GPIO_WIDTH-1:0] gpio_pins_t;

endpackage

`default_nettype wire

// ==== hw/periph_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module periph_subsystem
  import bus_pkg::*;
  import periph_pkg::*;
(
  input  wire             core_clk,
  input  wire             rst_i,

  input  wire             fetch_valid_i,
  input  wire addr_t      fetch_addr_i,
  output logic            fetch_valid_o,
  output inst_t           fetch_inst_o,
  output addr_t           fetch_addr_o,

  input  wire             mem_valid_i,
  input  wire             mem_read_i,
  input  wire             mem_write_i,
  input  wire addr_t      mem_addr_i,
  input  wire data_t      mem_wdata_i,
  output logic            mem_valid_o,
  output data_t           mem_rdata_o,

  input  wire gpio_pins_t gpio_a_in_i,
  output gpio_pins_t      gpio_a_out_o,
  output gpio_pins_t      gpio_a_oe_o,

  input  wire gpio_pins_t gpio_b_in_i,
  output gpio_pins_t      gpio_b_out_o,
  output gpio_pins_t      gpio_b_oe_o
);

  logic       ram0_fetch_valid;
  fetch_rsp_t ram0_fetch_rsp;
  logic       ram1_fetch_valid;
  fetch_rsp_t ram1_fetch_rsp;
  fetch_rsp_t fetch_rsp;

  logic       ram0_valid;
  data_t      ram0_rdata;
  logic       ram1_valid;
  data_t      ram1_rdata;
  logic       gpio_a_valid;
  data_t      gpio_a_rdata;
  logic       gpio_b_valid;
  data_t      gpio_b_rdata;
  logic       mem_grp_valid;
  data_t      mem_grp_rdata;
  logic       gpio_grp_valid;
  data_t      gpio_grp_rdata;

  mem_block #(
    .BASE_ADDR(`PS_RAM0_BASE),
    .MEM_DEPTH(`PS_MEM_DEPTH)
  ) ram0 (
    .core_clk     (core_clk),
    .rst_i        (rst_i),
    .fetch_valid_i(fetch_valid_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_valid_o(ram0_fetch_valid),
    .fetch_rsp_o  (ram0_fetch_rsp),
    .mem_valid_i  (mem_valid_i),
    .mem_read_i   (mem_read_i),
    .mem_write_i  (mem_write_i),
    .mem_addr_i   (mem_addr_i),
    .mem_wdata_i  (mem_wdata_i),
    .mem_valid_o  (ram0_valid),
    .mem_rdata_o  (ram0_rdata)
  );

  mem_block #(
    .BASE_ADDR(`PS_RAM1_BASE),
    .MEM_DEPTH(`PS_MEM_DEPTH)
  ) ram1 (
    .core_clk     (core_clk),
    .rst_i        (rst_i),
    .fetch_valid_i(fetch_valid_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_valid_o(ram1_fetch_valid),
    .fetch_rsp_o  (ram1_fetch_rsp),
    .mem_valid_i  (mem_valid_i),
    .mem_read_i   (mem_read_i),
    .mem_write_i  (mem_write_i),
    .mem_addr_i   (mem_addr_i),
    .mem_wdata_i  (mem_wdata_i),
    .mem_valid_o  (ram1_valid),
    .mem_rdata_o  (ram1_rdata)
  );

  gpio_port #(.BASE_ADDR(`PS_GPIO_A_BASE)) gpio_a (
    .core_clk   (core_clk),
    .rst_i      (rst_i),
    .mem_valid_i(mem_valid_i),
    .mem_read_i (mem_read_i),
    .mem_write_i(mem_write_i),
    .mem_addr_i (mem_addr_i),
    .mem_wdata_i(mem_wdata_i),
    .mem_valid_o(gpio_a_valid),
    .mem_rdata_o(gpio_a_rdata),
    .pin_in_i   (gpio_a_in_i),
    .pin_out_o  (gpio_a_out_o),
    .pin_oe_o   (gpio_a_oe_o)
  );

  gpio_port #(.BASE_ADDR(`PS_GPIO_B_BASE)) gpio_b (
    .core_clk   (core_clk),
    .rst_i      (rst_i),
    .mem_valid_i(mem_valid_i),
    .mem_read_i (mem_read_i),
    .mem_write_i(mem_write_i),
    .mem_addr_i (mem_addr_i),
    .mem_wdata_i(mem_wdata_i),
    .mem_valid_o(gpio_b_valid),
    .mem_rdata_o(gpio_b_rdata),
    .pin_in_i   (gpio_b_in_i),
    .pin_out_o  (gpio_b_out_o),
    .pin_oe_o   (gpio_b_oe_o)
  );

  // Fetch tree, one level
  resp_merge #(.payload_t(fetch_rsp_t)) fetch_merge (
    .core_clk     (core_clk),
    .rst_i        (rst_i),
    .port0_valid_i(ram0_fetch_valid),
    .port0_data_i (ram0_fetch_rsp),
    .port1_valid_i(ram1_fetch_valid),
    .port1_data_i (ram1_fetch_rsp),
    .valid_o      (fetch_valid_o),
    .data_o       (fetch_rsp)
  );

  assign fetch_inst_o = fetch_rsp.inst;
  assign fetch_addr_o = fetch_rsp.addr;

  // Data tree, two levels
  resp_merge #(.payload_t(data_t)) mem_merge (
    .core_clk     (core_clk),
    .rst_i        (rst_i),
    .port0_valid_i(ram0_valid),
    .port0_data_i (ram0_rdata),
    .port1_valid_i(ram1_valid),
    .port1_data_i (ram1_rdata),
    .valid_o      (mem_grp_valid),
    .data_o       (mem_grp_rdata)
  );

  resp_merge #(.payload_t(data_t)) gpio_merge (
    .core_clk     (core_clk),
    .rst_i        (rst_i),
    .port0_valid_i(gpio_a_valid),
    .port0_data_i (gpio_a_rdata),
    .port1_valid_i(gpio_b_valid),
    .port1_data_i (gpio_b_rdata),
    .valid_o      (gpio_grp_valid),
    .data_o       (gpio_grp_rdata)
  );

  resp_merge #(.payload_t(data_t)) data_merge (
    .core_clk     (core_clk),
    .rst_i        (rst_i),
    .port0_valid_i(mem_grp_valid),
    .port0_data_i (mem_grp_rdata),
    .port1_valid_i(gpio_grp_valid),
    .port1_data_i (gpio_grp_rdata),
    .valid_o      (mem_valid_o),
    .data_o       (mem_rdata_o)
  );

endmodule

`default_nettype wire

// ==== hw/resp_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module resp_merge #(
  parameter type payload_t = logic [31:0]
) (
  input  wire           core_clk,
  input  wire           rst_i,

  input  wire           port0_valid_i,
  input  wire payload_t port0_data_i,
  input  wire           port1_valid_i,
  input  wire payload_t port1_data_i,

  output logic          valid_o,
  output payload_t      data_o
);

  always_ff @(posedge core_clk) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= port0_valid_i || port1_valid_i;
    end
  end

  // Port 0 wins, last payload held while idle
  always_ff @(posedge core_clk) begin
    if (port0_valid_i) begin
      data_o <= port0_data_i;
    end else if (port1_valid_i) begin
      data_o <= port1_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== include/periph_consts.svh ====
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Address map of the peripheral bus
`define PS_RAM0_BASE    32'h2000_0000
`define PS_RAM1_BASE    32'h2100_0000
`define PS_GPIO_A_BASE  32'h8000_0000
`define PS_GPIO_B_BASE  32'h8000_0040

// Sizes
`define PS_MEM_DEPTH    256   // Words per RAM block
`define PS_GPIO_WIDTH   8     // Pins per GPIO port

`endif

// ==== tb.f ====
+incdir+include
hw/bus_pkg.sv
hw/periph_pkg.sv
hw/mem_block.sv
hw/gpio_port.sv
hw/resp_merge.sv
hw/periph_subsystem.sv
verification/tb_periph_subsystem.sv

// ==== verification/tb_periph_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module tb_periph_subsystem
  import bus_pkg::*;
  import periph_pkg::*;
();

  localparam int    TIMEOUT_CYCLES = 3000;  // About 1330 issue cycles plus drain
  localparam int    DEPTH          = `PS_MEM_DEPTH;
  localparam addr_t RAM_BYTES      = 4 * `PS_MEM_DEPTH;

  logic       core_clk = 1'b0;
  logic       rst_i;
  logic       fetch_valid_i;
  addr_t      fetch_addr_i;
  logic       fetch_valid_o;
  inst_t      fetch_inst_o;
  addr_t      fetch_addr_o;
  logic       mem_valid_i;
  logic       mem_read_i;
  logic       mem_write_i;
  addr_t      mem_addr_i;
  data_t      mem_wdata_i;
  logic       mem_valid_o;
  data_t      mem_rdata_o;
  gpio_pins_t gpio_a_in_i;
  gpio_pins_t gpio_a_out_o;
  gpio_pins_t gpio_a_oe_o;
  gpio_pins_t gpio_b_in_i;
  gpio_pins_t gpio_b_out_o;
  gpio_pins_t gpio_b_oe_o;

  // Reference model state
  data_t      ram0_m [DEPTH];
  data_t      ram1_m [DEPTH];
  gpio_pins_t out_a_m = '0;
  gpio_pins_t dir_a_m = '0;
  gpio_pins_t out_b_m = '0;
  gpio_pins_t dir_b_m = '0;
  gpio_pins_t in_a_m = '0;  // Pin value held by the sampling register
  gpio_pins_t in_b_m = '0;

  int     cycle = 0;
  integer seed;
  string  test_name;

  // Expected responses tagged with their due cycle
  int    fetch_due_q[$];
  inst_t inst_exp_q[$];
  addr_t addr_exp_q[$];
  string fetch_name_q[$];
  int    data_due_q[$];
  data_t data_exp_q[$];
  string data_name_q[$];

  periph_subsystem periph_subsystem_i (
    .core_clk     (core_clk),
    .rst_i        (rst_i),
    .fetch_valid_i(fetch_valid_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_valid_o(fetch_valid_o),
    .fetch_inst_o (fetch_inst_o),
    .fetch_addr_o (fetch_addr_o),
    .mem_valid_i  (mem_valid_i),
    .mem_read_i   (mem_read_i),
    .mem_write_i  (mem_write_i),
    .mem_addr_i   (mem_addr_i),
    .mem_wdata_i  (mem_wdata_i),
    .mem_valid_o  (mem_valid_o),
    .mem_rdata_o  (mem_rdata_o),
    .gpio_a_in_i  (gpio_a_in_i),
    .gpio_a_out_o (gpio_a_out_o),
    .gpio_a_oe_o  (gpio_a_oe_o),
    .gpio_b_in_i  (gpio_b_in_i),
    .gpio_b_out_o (gpio_b_out_o),
    .gpio_b_oe_o  (gpio_b_oe_o)
  );

  always #20 core_clk = ~core_clk;  // 40 ns period

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at cycle %0d", cycle);
  endtask

  always @(posedge core_clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles without finishing", cycle));
    end
  end

  function automatic logic in_window(input addr_t a, input addr_t base, input addr_t size);
    return (a >= base) && ((a - base) < size);
  endfunction

  function automatic int word_index(input addr_t a, input addr_t base);
    return int'((a - base) >> 2);
  endfunction

  function automatic addr_t rand_ram_addr();
    logic [31:0] r;
    r = $random(seed);
    return (r[31] ? `PS_RAM1_BASE : `PS_RAM0_BASE) + (r % RAM_BYTES);
  endfunction

  // Addresses just outside every decoded window
  function automatic addr_t rand_unmapped_addr();
    logic [31:0] r;
    r = $random(seed);
    case (r[30:28] % 6)
      0:       return `PS_RAM0_BASE + RAM_BYTES + {r[9:2], 2'b00};
      1:       return `PS_RAM1_BASE + RAM_BYTES + {r[9:2], 2'b00};
      2:       return `PS_RAM0_BASE - 4 - {r[9:2], 2'b00};
      3:       return `PS_GPIO_A_BASE + 16 + {r[4:2], 2'b00};
      4:       return `PS_GPIO_B_BASE + 16 + {r[4:2], 2'b00};
      default: return {4'hC, r[27:0]};
    endcase
  endfunction

  task automatic gpio_access(input logic [3:0] off, input gpio_pins_t in_m,
                             inout gpio_pins_t out_m, inout gpio_pins_t dir_m,
                             output data_t rd);
    case (off)
      GPIO_REG_OUT: rd = data_t'(out_m);
      GPIO_REG_DIR: rd = data_t'(dir_m);
      GPIO_REG_IN:  rd = data_t'(in_m);
      default:      rd = '0;
    endcase
    if (mem_write_i && off == GPIO_REG_OUT) out_m = mem_wdata_i[`PS_GPIO_WIDTH-1:0];
    if (mem_write_i && off == GPIO_REG_DIR) dir_m = mem_wdata_i[`PS_GPIO_WIDTH-1:0];
  endtask

  // Reads use the model before this request's write lands
  task automatic model_request();
    data_t      word;
    data_t      rd;
    logic       hit;
    int         idx;
    logic [3:0] off;
    off = {mem_addr_i[3:2], 2'b00};
    if (fetch_valid_i) begin
      hit = 1'b1;
      if (in_window(fetch_addr_i, `PS_RAM0_BASE, RAM_BYTES)) begin
        word = ram0_m[word_index(fetch_addr_i, `PS_RAM0_BASE)];
      end else if (in_window(fetch_addr_i, `PS_RAM1_BASE, RAM_BYTES)) begin
        word = ram1_m[word_index(fetch_addr_i, `PS_RAM1_BASE)];
      end else begin
        hit = 1'b0;
      end
      if (hit) begin
        fetch_due_q.push_back(cycle + 2);
        inst_exp_q.push_back(fetch_addr_i[1] ? word[15:0] : word[31:16]);  // Upper half at bit 1 low
        addr_exp_q.push_back(fetch_addr_i);
        fetch_name_q.push_back(test_name);
      end
    end
    if (mem_valid_i) begin
      hit = 1'b1;
      rd  = '0;
      if (in_window(mem_addr_i, `PS_RAM0_BASE, RAM_BYTES)) begin
        idx = word_index(mem_addr_i, `PS_RAM0_BASE);
        rd  = ram0_m[idx];
        if (mem_write_i) ram0_m[idx] = mem_wdata_i;
      end else if (in_window(mem_addr_i, `PS_RAM1_BASE, RAM_BYTES)) begin
        idx = word_index(mem_addr_i, `PS_RAM1_BASE);
        rd  = ram1_m[idx];
        if (mem_write_i) ram1_m[idx] = mem_wdata_i;
      end else if (in_window(mem_addr_i, `PS_GPIO_A_BASE, 16)) begin
        gpio_access(off, in_a_m, out_a_m, dir_a_m, rd);
      end else if (in_window(mem_addr_i, `PS_GPIO_B_BASE, 16)) begin
        gpio_access(off, in_b_m, out_b_m, dir_b_m, rd);
      end else begin
        hit = 1'b0;
      end
      if (hit) begin
        data_due_q.push_back(cycle + 3);
        data_exp_q.push_back(mem_read_i ? rd : '0);  // Writes answer zero
        data_name_q.push_back(test_name);
      end
    end
  endtask

  task automatic check_responses();
    assert ({gpio_a_out_o, gpio_a_oe_o, gpio_b_out_o, gpio_b_oe_o} ===
            {out_a_m, dir_a_m, out_b_m, dir_b_m})
      else abort_run($sformatf("Fail %s gpio pins: expected %h, actual %h", test_name,
                               {out_a_m, dir_a_m, out_b_m, dir_b_m},
                               {gpio_a_out_o, gpio_a_oe_o, gpio_b_out_o, gpio_b_oe_o}));
    if (fetch_due_q.size() > 0 && fetch_due_q[0] == cycle) begin
      assert (fetch_valid_o === 1'b1)
        else abort_run($sformatf("No fetch response in %s at cycle %0d", fetch_name_q[0], cycle));
      assert ({fetch_inst_o, fetch_addr_o} === {inst_exp_q[0], addr_exp_q[0]})
        else abort_run($sformatf("Fail %s fetch: expected %h/%h, actual %h/%h", fetch_name_q[0],
                                 inst_exp_q[0], addr_exp_q[0], fetch_inst_o, fetch_addr_o));
      void'(fetch_due_q.pop_front());
      void'(inst_exp_q.pop_front());
      void'(addr_exp_q.pop_front());
      void'(fetch_name_q.pop_front());
    end else begin
      assert (fetch_valid_o === 1'b0)
        else abort_run($sformatf("Unexpected fetch response in %s at cycle %0d",
                                 test_name, cycle));
    end
    if (data_due_q.size() > 0 && data_due_q[0] == cycle) begin
      assert (mem_valid_o === 1'b1)
        else abort_run($sformatf("No data response in %s at cycle %0d", data_name_q[0], cycle));
      assert (mem_rdata_o === data_exp_q[0])
        else abort_run($sformatf("Fail %s data: expected %h, actual %h", data_name_q[0],
                                 data_exp_q[0], mem_rdata_o));
      void'(data_due_q.pop_front());
      void'(data_exp_q.pop_front());
      void'(data_name_q.pop_front());
    end else begin
      assert (mem_valid_o === 1'b0)
        else abort_run($sformatf("Unexpected data response in %s at cycle %0d",
                                 test_name, cycle));
    end
  endtask

  // Outputs and bus inputs are both stable at the falling edge
  always @(negedge core_clk) begin
    if (!rst_i) begin
      check_responses();
      model_request();
    end
    in_a_m = gpio_a_in_i;
    in_b_m = gpio_b_in_i;
  end

  task automatic drive_cycle(input logic fv, input addr_t fa, input logic mv, input logic wr,
                             input addr_t ma, input data_t wd);
    @(posedge core_clk);
    fetch_valid_i <= fv;
    fetch_addr_i  <= fa;
    mem_valid_i   <= mv;
    mem_read_i    <= mv && !wr;
    mem_write_i   <= mv && wr;
    mem_addr_i    <= ma;
    mem_wdata_i   <= wd;
  endtask

  initial begin
    int          i;
    logic [31:0] r;
    addr_t       fa;
    seed          = 32'h1ebb4e0c;
    test_name     = "reset";
    rst_i         = 1'b1;
    fetch_valid_i = 1'b1;  // Live requests during reset must not leak out
    fetch_addr_i  = `PS_RAM0_BASE;
    mem_valid_i   = 1'b1;
    mem_read_i    = 1'b1;
    mem_write_i   = 1'b0;
    mem_addr_i    = `PS_RAM1_BASE;
    mem_wdata_i   = '0;
    gpio_a_in_i   = '0;
    gpio_b_in_i   = '0;
    repeat (2) @(posedge core_clk);
    rst_i         <= 1'b0;
    fetch_valid_i <= 1'b0;
    mem_valid_i   <= 1'b0;
    mem_read_i    <= 1'b0;
    repeat (2) drive_cycle(0, '0, 0, 0, '0, '0);

    test_name = "mem_fill";  // Every word defined before any read
    for (i = 0; i < DEPTH; i++) begin
      drive_cycle(0, '0, 1, 1, `PS_RAM0_BASE + 4 * i, $random(seed));
      drive_cycle(0, '0, 1, 1, `PS_RAM1_BASE + 4 * i, $random(seed));
    end

    test_name = "mem_rw";
    for (i = 0; i < 250; i++) begin
      r = $random(seed);
      drive_cycle(0, '0, 1, r[0], rand_ram_addr(), $random(seed));
    end

    test_name = "fetch";
    for (i = 0; i < 250; i++) begin
      r  = $random(seed);
      fa = rand_ram_addr();
      drive_cycle(1, fa, r[2], 1, (r[1:0] == 2'b00) ? fa : rand_ram_addr(), $random(seed));
    end

    test_name = "gpio_regs";
    for (i = 0; i < 150; i++) begin
      r = $random(seed);
      drive_cycle(0, '0, 1, r[3], (r[0] ? `PS_GPIO_B_BASE : `PS_GPIO_A_BASE) + {r[2:1], 2'b00},
                  $random(seed));
    end

    test_name = "gpio_in";
    for (i = 0; i < 20; i++) begin
      drive_cycle(0, '0, 0, 0, '0, '0);
      r = $random(seed);
      gpio_a_in_i <= gpio_pins_t'(r);
      gpio_b_in_i <= gpio_pins_t'(r >> 8);
      drive_cycle(0, '0, 0, 0, '0, '0);
      repeat (3) begin
        r = $random(seed);
        drive_cycle(0, '0, 1, 0, (r[0] ? `PS_GPIO_B_BASE : `PS_GPIO_A_BASE) + 32'h8, '0);
      end
    end

    test_name = "unmapped";
    for (i = 0; i < 60; i++) begin
      r = $random(seed);
      drive_cycle(1, rand_unmapped_addr(), 1, r[0], rand_unmapped_addr(), $random(seed));
    end

    test_name = "drain";
    repeat (6) drive_cycle(0, '0, 0, 0, '0, '0);
    if (fetch_due_q.size() == 0 && data_due_q.size() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abort_run("Expected responses still pending at end of run");
    end
  end

endmodule

`default_nettype wire
